//--- verification/mm_patterns.txt
// Per test: 16 packed I words, 12 packed W words, then 48 expected C values by address
// A packed word holds two Q8.8 elements, the odd row in the upper half
// Test 1, values 1.0 and 2.0
02000100 01000100 01000100 01000100 02000100 02000200 01000100 01000100
02000100 01000100 02000200 01000100 02000100 02000200 02000200 01000100
02000100 01000100 01000100 01000100 02000100 02000200
01000100 01000100 02000100 01000100 02000200 01000100
0400 0500 0500 0600 0500 0600 0500 0700 0600 0800 0600 0800
0500 0600 0700 0800 0600 0700 0600 0800 0800 0A00 0700 0900
0500 0600 0600 0700 0700 0800 0600 0800 0700 0900 0800 0A00
0600 0700 0800 0900 0800 0900 0700 0900 0900 0B00 0900 0B00
// Test 2, negative operands and saturation
FF000100 FF000100 FF000100 FF000100 10000200 10000000 0000FE00 00000000
0080F800 0080F800 0080F800 0080F800 7F00FF80 00000180 00000000 80000300
FF000100 00000200 01000300 00000400 F0001000 F0001000
00001000 00001000 02000080 FE00FF80 02000040 FE000000
0A00 0000 4000 E000 0040 0000 F600 0000 C000 2000 FFC0 0000
FC00 FC00 0000 E000 0080 0000 3000 F000 7FFF 8000 0000 0000
B000 0000 8000 7FFF FE00 0000 0500 0000 2000 F000 0020 0000
0E80 0080 4000 F000 FF00 F600 8000 8100 F000 8000 3F80 7FFF
// Test 3, reload with quarter steps and selecting weights
FD00FC00 FD40FC40 FD80FC80 FDC0FCC0 FF00FE00 FF40FE40 FF80FE80 FFC0FEC0
01000000 01400040 01800080 01C000C0 03000200 03400240 03800280 03C002C0
00000100 01000000 00000000 00000000 00000000 00000000
00000100 01000000 FF000100 00000100 00000100 02000100
FC00 FC40 FC80 FCC0 F180 FD80 FD00 FD40 FD80 FDC0 F580 FE80
FE00 FE40 FE80 FEC0 F980 FF80 FF00 FF40 FF80 FFC0 FD80 0080
0000 0040 0080 00C0 0180 0180 0100 0140 0180 01C0 0580 0280
0200 0240 0280 02C0 0980 0380 0300 0340 0380 03C0 0D80 0480

//--- compile.f
design/mm_pkg.sv
design/mm_array_if.sv
design/mm_bram.sv
design/mm_pe.sv
design/mm_systolic_array.sv
design/mm_tile_ctrl.sv
design/mm_top.sv
verification/tb_clock_gen.sv
verification/tb_mm_top.sv

//--- Bender.yml
package:
  name: mm_accel

sources:
  - design/mm_pkg.sv
  - design/mm_array_if.sv
  - design/mm_bram.sv
  - design/mm_pe.sv
  - design/mm_systolic_array.sv
  - design/mm_tile_ctrl.sv
  - design/mm_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_mm_top.sv

//--- verification/tb_mm_top.sv
// Matrix multiply accelerator testbench

`timescale 1ns/1ps

module tb_mm_top;

    localparam int WIDTH          = mm_pkg::DEF_WIDTH;
    localparam int BLOCK_SIZE     = mm_pkg::DEF_BLOCK_SIZE;
    localparam int INNER          = mm_pkg::DEF_INNER_DIMENSION;
    localparam int W_ROWS         = mm_pkg::DEF_W_OUTER_DIMENSION;
    localparam int I_ROWS         = mm_pkg::DEF_I_OUTER_DIMENSION;
    localparam int I_WORDS        = I_ROWS / BLOCK_SIZE * INNER; // Packed memory words
    localparam int W_WORDS        = W_ROWS / BLOCK_SIZE * INNER;
    localparam int C_WORDS        = I_ROWS * W_ROWS;
    localparam int TEST_WORDS     = I_WORDS + W_WORDS + C_WORDS;
    localparam int NUM_TESTS      = 3;
    localparam int NUM_TILES      = (I_ROWS / BLOCK_SIZE) * (W_ROWS / BLOCK_SIZE);
    localparam int TILE_CYCLES    = INNER + 2*BLOCK_SIZE + BLOCK_SIZE*BLOCK_SIZE;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES =
        2 * NUM_TESTS * (I_WORDS + W_WORDS + NUM_TILES*TILE_CYCLES + 20) + RESET_CYCLES;
    localparam int I_ADDR_WIDTH   = $clog2(I_WORDS);
    localparam int W_ADDR_WIDTH   = $clog2(W_WORDS);
    localparam int OUT_ADDR_WIDTH = $clog2(C_WORDS);

    logic                        clk;
    logic                        arst_n;
    logic                        start;
    logic                        wb_we;
    logic [W_ADDR_WIDTH-1:0]     wb_addr;
    logic [BLOCK_SIZE*WIDTH-1:0] wb_data;
    logic                        in_we;
    logic [I_ADDR_WIDTH-1:0]     in_addr;
    logic [BLOCK_SIZE*WIDTH-1:0] in_data;
    logic                        out_valid;
    logic [OUT_ADDR_WIDTH-1:0]   out_addr;
    logic [WIDTH-1:0]            out_data;
    logic                        done;
    logic                        busy;

    logic [BLOCK_SIZE*WIDTH-1:0] patterns [NUM_TESTS*TEST_WORDS]; // I, W, then C per test
    logic                        seen [C_WORDS];
    int                          cycle_count = 0;
    int                          error_count = 0;

    tb_clock_gen #(
        .PERIOD_NS (10.0)
    ) i_tb_clock_gen (
        .clk (clk)
    );

    mm_top #(
        .WIDTH             (WIDTH),
        .FRAC_WIDTH        (mm_pkg::DEF_FRAC_WIDTH),
        .BLOCK_SIZE        (BLOCK_SIZE),
        .INNER_DIMENSION   (INNER),
        .W_OUTER_DIMENSION (W_ROWS),
        .I_OUTER_DIMENSION (I_ROWS)
    ) i_mm_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .wb_we     (wb_we),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .in_we     (in_we),
        .in_addr   (in_addr),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_data  (out_data),
        .done      (done),
        .busy      (busy)
    );

    task automatic stop_on_error(input string reason);
        error_count++;
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_idle(input string phase);
        assert (!out_valid && !done && !busy)
        else stop_on_error($sformatf("%s: DUT not idle, out_valid %b done %b busy %b",
                                     phase, out_valid, done, busy));
    endtask

    // Controller state is only visible through the hierarchy
    task automatic check_reset_state(input string phase);
        assert (i_mm_top.i_mm_tile_ctrl.state == mm_pkg::CTRL_IDLE)
        else stop_on_error($sformatf("%s: controller state is not idle", phase));
    endtask

    task automatic load_memories(input int test);
        int base;
        base = test * TEST_WORDS;
        for (int a = 0; a < I_WORDS; a++)
        begin
            in_we   = 1'b1;
            in_addr = I_ADDR_WIDTH'(a);
            in_data = patterns[base + a];
            next_cycle();
        end
        in_we = 1'b0;
        for (int a = 0; a < W_WORDS; a++)
        begin
            wb_we   = 1'b1;
            wb_addr = W_ADDR_WIDTH'(a);
            wb_data = patterns[base + I_WORDS + a]; // W words follow the I words
            next_cycle();
        end
        wb_we = 1'b0;
    endtask

    task automatic run_test(input int test, input string name);
        int               base;
        int               results;
        bit               finished;
        logic [WIDTH-1:0] expected;
        base     = test * TEST_WORDS + I_WORDS + W_WORDS;
        results  = 0;
        finished = 1'b0;
        for (int a = 0; a < C_WORDS; a++)
            seen[a] = 1'b0;
        load_memories(test);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        while (!finished)
        begin
            if (out_valid)
            begin
                assert (int'(out_addr) < C_WORDS && !seen[out_addr])
                else stop_on_error($sformatf("%s: address %0d out of range or emitted twice",
                                             name, out_addr));
                expected = patterns[base + int'(out_addr)][WIDTH-1:0];
                assert (out_data == expected)
                else stop_on_error($sformatf(
                    "mismatch in %s at address %0d: expected %h, actual %h",
                    name, out_addr, expected, out_data));
                seen[out_addr] = 1'b1;
                results++;
            end
            if (done)
            begin
                // With distinct addresses the count proves full coverage
                assert (results == C_WORDS && !busy)
                else stop_on_error($sformatf("%s: done after %0d of %0d results, busy %b",
                                             name, results, C_WORDS, busy));
                finished = 1'b1;
            end
            else
            begin
                assert (busy)
                else stop_on_error($sformatf("%s: busy fell before done", name));
            end
            next_cycle();
        end
        check_idle(name); // Done lasts a single cycle
    endtask

    // Watchdog against a DUT that never finishes
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_on_error($sformatf("timeout: run not finished within %0d cycles",
                                    TIMEOUT_CYCLES));
    end

    initial
    begin
        arst_n  = 1'b0;
        start   = 1'b0;
        wb_we   = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        in_we   = 1'b0;
        in_addr = '0;
        in_data = '0;
        $readmemh("verification/mm_patterns.txt", patterns);
        assert (!$isunknown(patterns[NUM_TESTS*TEST_WORDS-1]))
        else stop_on_error("pattern file is missing or too short");
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        check_idle("reset");
        check_reset_state("reset");
        arst_n = 1'b1;
        repeat (4)
        begin
            next_cycle();
            check_idle("after reset");
            check_reset_state("after reset");
        end
        run_test(0, "pos_small");
        run_test(1, "neg_sat");
        run_test(2, "reload"); // Fresh data in both memories
        if (error_count == 0)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            stop_on_error("run ended with failed checks");
        end
    end

endmodule

//--- verification/tb_clock_gen.sv
// Testbench clock source

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk; // 50 percent duty cycle
    end

endmodule

//--- design/mm_top.sv
// Matrix multiply accelerator top

`timescale 1ns/1ps

module mm_top #(
    parameter  int WIDTH             = mm_pkg::DEF_WIDTH,
    parameter  int FRAC_WIDTH        = mm_pkg::DEF_FRAC_WIDTH,
    parameter  int BLOCK_SIZE        = mm_pkg::DEF_BLOCK_SIZE,
    parameter  int INNER_DIMENSION   = mm_pkg::DEF_INNER_DIMENSION,
    parameter  int W_OUTER_DIMENSION = mm_pkg::DEF_W_OUTER_DIMENSION,
    parameter  int I_OUTER_DIMENSION = mm_pkg::DEF_I_OUTER_DIMENSION,
    localparam int W_DEPTH           = W_OUTER_DIMENSION / BLOCK_SIZE * INNER_DIMENSION,
    localparam int I_DEPTH           = I_OUTER_DIMENSION / BLOCK_SIZE * INNER_DIMENSION,
    localparam int W_ADDR_WIDTH      = mm_pkg::addr_width(W_DEPTH),
    localparam int I_ADDR_WIDTH      = mm_pkg::addr_width(I_DEPTH),
    localparam int OUT_ADDR_WIDTH    =
        mm_pkg::addr_width(I_OUTER_DIMENSION * W_OUTER_DIMENSION)
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        start,
    input  logic                        wb_we,   // Weight memory write
    input  logic [W_ADDR_WIDTH-1:0]     wb_addr,
    input  logic [BLOCK_SIZE*WIDTH-1:0] wb_data,
    input  logic                        in_we,   // Input memory write
    input  logic [I_ADDR_WIDTH-1:0]     in_addr,
    input  logic [BLOCK_SIZE*WIDTH-1:0] in_data,
    output logic                        out_valid,
    output logic [OUT_ADDR_WIDTH-1:0]   out_addr,
    output logic [WIDTH-1:0]            out_data,
    output logic                        done,
    output logic                        busy
);

    logic [I_ADDR_WIDTH-1:0] i_raddr;
    logic [W_ADDR_WIDTH-1:0] w_raddr;

    mm_array_if #(
        .WIDTH      (WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) arr_if ();

    // Weight rows feed the array columns
    mm_bram #(
        .WIDTH      (WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE),
        .DEPTH      (W_DEPTH)
    ) i_w_bram (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (wb_we),
        .waddr  (wb_addr),
        .raddr  (w_raddr),
        .wdata  (wb_data),
        .rdata  (arr_if.b_vec)
    );

    mm_bram #(
        .WIDTH      (WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE),
        .DEPTH      (I_DEPTH)
    ) i_i_bram (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (in_we),
        .waddr  (in_addr),
        .raddr  (i_raddr),
        .wdata  (in_data),
        .rdata  (arr_if.a_vec)
    );

    mm_tile_ctrl #(
        .WIDTH             (WIDTH),
        .BLOCK_SIZE        (BLOCK_SIZE),
        .INNER_DIMENSION   (INNER_DIMENSION),
        .W_OUTER_DIMENSION (W_OUTER_DIMENSION),
        .I_OUTER_DIMENSION (I_OUTER_DIMENSION)
    ) i_mm_tile_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .ctl       (arr_if.ctrl),
        .i_raddr   (i_raddr),
        .w_raddr   (w_raddr),
        .out_valid (out_valid),
        .out_addr  (out_addr),
        .out_data  (out_data),
        .done      (done),
        .busy      (busy)
    );

    mm_systolic_array #(
        .WIDTH      (WIDTH),
        .FRAC_WIDTH (FRAC_WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) i_mm_systolic_array (
        .clk    (clk),
        .arst_n (arst_n),
        .arr    (arr_if.array)
    );

endmodule

//--- design/mm_tile_ctrl.sv
// Tile sequencing controller

`timescale 1ns/1ps

module mm_tile_ctrl #(
    parameter  int WIDTH             = 16,
    parameter  int BLOCK_SIZE        = 2,
    parameter  int INNER_DIMENSION   = 4,
    parameter  int W_OUTER_DIMENSION = 6,
    parameter  int I_OUTER_DIMENSION = 8,
    localparam int ROW_SIZE_MAT_C    = I_OUTER_DIMENSION / BLOCK_SIZE,
    localparam int COL_SIZE_MAT_C    = W_OUTER_DIMENSION / BLOCK_SIZE,
    localparam int I_ADDR_WIDTH      = mm_pkg::addr_width(ROW_SIZE_MAT_C * INNER_DIMENSION),
    localparam int W_ADDR_WIDTH      = mm_pkg::addr_width(COL_SIZE_MAT_C * INNER_DIMENSION),
    localparam int OUT_ADDR_WIDTH    =
        mm_pkg::addr_width(I_OUTER_DIMENSION * W_OUTER_DIMENSION)
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      start,
    mm_array_if.ctrl                  ctl,
    output logic [I_ADDR_WIDTH-1:0]   i_raddr,
    output logic [W_ADDR_WIDTH-1:0]   w_raddr,
    output logic                      out_valid,
    output logic [OUT_ADDR_WIDTH-1:0] out_addr,
    output logic [WIDTH-1:0]          out_data,
    output logic                      done,
    output logic                      busy
);

    // k counter also times the drain phase
    localparam int STEP_MAX  = (INNER_DIMENSION > 2*BLOCK_SIZE) ?
                               INNER_DIMENSION : 2*BLOCK_SIZE;
    localparam int K_WIDTH   = mm_pkg::addr_width(STEP_MAX);
    localparam int E_WIDTH   = mm_pkg::addr_width(BLOCK_SIZE * BLOCK_SIZE);
    localparam int ROW_WIDTH = mm_pkg::addr_width(ROW_SIZE_MAT_C);
    localparam int COL_WIDTH = mm_pkg::addr_width(COL_SIZE_MAT_C);

    mm_pkg::ctrl_state_e  state;
    logic [ROW_WIDTH-1:0] tile_row;
    logic [COL_WIDTH-1:0] tile_col;
    logic [K_WIDTH-1:0]   k_cnt;
    logic [E_WIDTH-1:0]   emit_cnt;
    logic                 last_tile;
    int                   emit_row;
    int                   emit_col;

    assign last_tile = (tile_row == ROW_WIDTH'(ROW_SIZE_MAT_C - 1)) &&
                       (tile_col == COL_WIDTH'(COL_SIZE_MAT_C - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= mm_pkg::CTRL_IDLE;
            tile_row <= '0;
            tile_col <= '0;
            k_cnt    <= '0;
            emit_cnt <= '0;
        end
        else
        begin
            case (state)
                mm_pkg::CTRL_IDLE:
                begin
                    if (start)
                    begin
                        state    <= mm_pkg::CTRL_FEED;
                        tile_row <= '0;
                        tile_col <= '0;
                        k_cnt    <= '0;
                    end
                end
                mm_pkg::CTRL_FEED:
                begin
                    k_cnt <= k_cnt + 1'b1;
                    if (k_cnt == K_WIDTH'(INNER_DIMENSION - 1))
                    begin
                        state <= mm_pkg::CTRL_DRAIN;
                        k_cnt <= '0;
                    end
                end
                mm_pkg::CTRL_DRAIN:
                begin
                    k_cnt <= k_cnt + 1'b1;
                    if (k_cnt == K_WIDTH'(2*BLOCK_SIZE - 1)) // Last PE has its final sum
                    begin
                        state    <= mm_pkg::CTRL_EMIT;
                        emit_cnt <= '0;
                    end
                end
                mm_pkg::CTRL_EMIT:
                begin
                    emit_cnt <= emit_cnt + 1'b1;
                    if (emit_cnt == E_WIDTH'(BLOCK_SIZE*BLOCK_SIZE - 1))
                    begin
                        k_cnt <= '0;
                        if (last_tile)
                        begin
                            state <= mm_pkg::CTRL_DONE;
                        end
                        else
                        begin
                            state <= mm_pkg::CTRL_FEED;
                            if (tile_col == COL_WIDTH'(COL_SIZE_MAT_C - 1))
                            begin
                                tile_col <= '0;
                                tile_row <= tile_row + 1'b1;
                            end
                            else
                            begin
                                tile_col <= tile_col + 1'b1;
                            end
                        end
                    end
                end
                default: state <= mm_pkg::CTRL_IDLE; // DONE lasts one cycle
            endcase
        end
    end

    // Read data arrives a cycle after the address
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ctl.feed_valid <= 1'b0;
        else
            ctl.feed_valid <= (state == mm_pkg::CTRL_FEED);
    end

    assign ctl.clear = (state == mm_pkg::CTRL_FEED) && (k_cnt == '0);
    assign i_raddr   = I_ADDR_WIDTH'(int'(tile_row) * INNER_DIMENSION + int'(k_cnt));
    assign w_raddr   = W_ADDR_WIDTH'(int'(tile_col) * INNER_DIMENSION + int'(k_cnt));

    // Row-major pick within the tile
    always_comb
    begin
        emit_row = int'(emit_cnt) / BLOCK_SIZE;
        emit_col = int'(emit_cnt) % BLOCK_SIZE;
        out_addr = OUT_ADDR_WIDTH'((int'(tile_row) * BLOCK_SIZE + emit_row) * W_OUTER_DIMENSION
                   + int'(tile_col) * BLOCK_SIZE + emit_col);
        out_data = ctl.result_vec[int'(emit_cnt)*WIDTH +: WIDTH];
    end

    assign out_valid = (state == mm_pkg::CTRL_EMIT);
    assign done      = (state == mm_pkg::CTRL_DONE);
    assign busy      = (state == mm_pkg::CTRL_FEED) || (state == mm_pkg::CTRL_DRAIN) ||
                       (state == mm_pkg::CTRL_EMIT);

endmodule

//--- design/mm_systolic_array.sv
// Systolic array with skew and scaling

`timescale 1ns/1ps

module mm_systolic_array #(
    parameter int WIDTH      = 16,
    parameter int FRAC_WIDTH = 8,
    parameter int BLOCK_SIZE = 2
) (
    input  logic        clk,
    input  logic        arst_n,
    mm_array_if.array   arr
);

    logic signed [WIDTH-1:0]   a_skewed [BLOCK_SIZE];
    logic signed [WIDTH-1:0]   b_skewed [BLOCK_SIZE];
    logic                      v_skewed [BLOCK_SIZE];

    logic signed [WIDTH-1:0]   a_fwd [BLOCK_SIZE][BLOCK_SIZE];
    logic signed [WIDTH-1:0]   b_fwd [BLOCK_SIZE][BLOCK_SIZE];
    logic                      v_fwd [BLOCK_SIZE][BLOCK_SIZE];
    logic signed [2*WIDTH-1:0] acc   [BLOCK_SIZE][BLOCK_SIZE];

    // Triangular delay lines where lane n is delayed n cycles
    for (genvar n = 0; n < BLOCK_SIZE; n++)
    begin : g_skew
        logic signed [WIDTH-1:0] a_dly [n+1];
        logic signed [WIDTH-1:0] b_dly [n+1];
        logic                    v_dly [n+1];

        assign a_dly[0] = arr.a_vec[n*WIDTH +: WIDTH];
        assign b_dly[0] = arr.b_vec[n*WIDTH +: WIDTH];
        assign v_dly[0] = arr.feed_valid; // Valid follows the row operands

        for (genvar d = 1; d <= n; d++)
        begin : g_stage
            always_ff @(posedge clk)
            begin
                a_dly[d] <= a_dly[d-1];
                b_dly[d] <= b_dly[d-1];
            end

            always_ff @(posedge clk or negedge arst_n)
            begin
                if (!arst_n)
                    v_dly[d] <= 1'b0;
                else
                    v_dly[d] <= v_dly[d-1];
            end
        end

        assign a_skewed[n] = a_dly[n];
        assign b_skewed[n] = b_dly[n];
        assign v_skewed[n] = v_dly[n];
    end

    for (genvar r = 0; r < BLOCK_SIZE; r++)
    begin : g_row
        for (genvar c = 0; c < BLOCK_SIZE; c++)
        begin : g_col
            logic signed [2*WIDTH-1:0] shifted;
            logic signed [WIDTH-1:0]   scaled;

            mm_pe #(
                .WIDTH (WIDTH)
            ) i_mm_pe (
                .clk       (clk),
                .arst_n    (arst_n),
                .clear     (arr.clear),
                .a_in      ((c == 0) ? a_skewed[r] : a_fwd[r][(c == 0) ? 0 : c-1]),
                .b_in      ((r == 0) ? b_skewed[c] : b_fwd[(r == 0) ? 0 : r-1][c]),
                .valid_in  ((c == 0) ? v_skewed[r] : v_fwd[r][(c == 0) ? 0 : c-1]),
                .a_out     (a_fwd[r][c]),
                .b_out     (b_fwd[r][c]),
                .valid_out (v_fwd[r][c]),
                .acc       (acc[r][c])
            );

            // Back to Q8.8 with a clamp when the upper bits are not all sign
            always_comb
            begin
                shifted = acc[r][c] >>> FRAC_WIDTH;
                if ((&shifted[2*WIDTH-1:WIDTH-1]) || !(|shifted[2*WIDTH-1:WIDTH-1]))
                    scaled = shifted[WIDTH-1:0];
                else if (shifted[2*WIDTH-1])
                    scaled = {1'b1, {(WIDTH-1){1'b0}}};
                else
                    scaled = {1'b0, {(WIDTH-1){1'b1}}};
            end

            assign arr.result_vec[(r*BLOCK_SIZE+c)*WIDTH +: WIDTH] = scaled;
        end
    end

endmodule

//--- design/mm_pe.sv
// Systolic processing element

`timescale 1ns/1ps

module mm_pe #(
    parameter int WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        clear,
    input  logic signed [WIDTH-1:0]     a_in,
    input  logic signed [WIDTH-1:0]     b_in,
    input  logic                        valid_in,
    output logic signed [WIDTH-1:0]     a_out,
    output logic signed [WIDTH-1:0]     b_out,
    output logic                        valid_out,
    output logic signed [2*WIDTH-1:0]   acc
);

    logic signed [2*WIDTH-1:0] product;

    assign product = a_in * b_in; // Full precision product

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            acc       <= '0;
            valid_out <= 1'b0;
        end
        else
        begin
            if (clear)
            begin
                acc <= '0;
            end
            else if (valid_in)
            begin
                acc <= acc + product; // Accumulate in the arrival cycle
            end
            valid_out <= valid_in;
        end
    end

    // a moves right and b moves down
    always_ff @(posedge clk)
    begin
        a_out <= a_in;
        b_out <= b_in;
    end

endmodule

//--- design/mm_bram.sv
// Operand memory

`timescale 1ns/1ps

module mm_bram #(
    parameter  int WIDTH      = 16,
    parameter  int BLOCK_SIZE = 2,
    parameter  int DEPTH      = 16,
    localparam int ADDR_WIDTH = mm_pkg::addr_width(DEPTH)
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        we,
    input  logic [ADDR_WIDTH-1:0]       waddr,
    input  logic [ADDR_WIDTH-1:0]       raddr,
    input  logic [BLOCK_SIZE*WIDTH-1:0] wdata,
    output logic [BLOCK_SIZE*WIDTH-1:0] rdata
);

    logic [BLOCK_SIZE*WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata; // Whole word without byte enables
        end
    end

    // Registered read with one cycle of latency
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rdata <= '0;
        end
        else
        begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- design/mm_array_if.sv
// Controller to array link

`timescale 1ns/1ps

interface mm_array_if #(
    parameter int WIDTH      = 16,
    parameter int BLOCK_SIZE = 2
) ();

    logic                                    clear;      // Zero all accumulators
    logic                                    feed_valid; // Operand vectors present
    logic [BLOCK_SIZE*WIDTH-1:0]             a_vec;      // One I element per row
    logic [BLOCK_SIZE*WIDTH-1:0]             b_vec;      // One W element per column
    logic [BLOCK_SIZE*BLOCK_SIZE*WIDTH-1:0]  result_vec; // Scaled results, row-major

    // Operand vectors come straight from memory read data
    modport ctrl (
        output clear,
        output feed_valid,
        input  result_vec
    );

    modport array (
        input  clear,
        input  feed_valid,
        input  a_vec,
        input  b_vec,
        output result_vec
    );

endinterface

//--- design/mm_pkg.sv
// Matrix multiply shared definitions

package mm_pkg;

    // Default dimensions of the accelerator
    localparam int DEF_WIDTH             = 16; // Q8.8 element width
    localparam int DEF_FRAC_WIDTH        = 8;
    localparam int DEF_BLOCK_SIZE        = 2;  // Systolic array is N x N
    localparam int DEF_INNER_DIMENSION   = 4;  // Shared columns of I and W
    localparam int DEF_W_OUTER_DIMENSION = 6;  // Weight rows
    localparam int DEF_I_OUTER_DIMENSION = 8;  // Input rows

    // Tile controller states
    typedef enum logic [2:0]
    {
        CTRL_IDLE,
        CTRL_FEED,  // Operands are read from memory
        CTRL_DRAIN, // Skewed operands still in flight
        CTRL_EMIT,  // One result per cycle
        CTRL_DONE
    } ctrl_state_e;

    // Address bits for a given depth with a floor of one
    function automatic int addr_width(input int depth);
        int bits;
        bits = (depth > 1) ? $clog2(depth) : 1;
        return bits;
    endfunction

endpackage
